// ==== src/cacheCtrl.sv ====
`timescale 1ns/1ns

module cacheCtrl import cachePkg::*; #(
  parameter int NUM_SETS = 64,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
) (
  input  logic              clk,
  input  logic              rst_n,
  // pipeline side
  input  logic              valid_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output logic [XLEN-1:0]   rdData_o,
  // registered way outputs
  input  logic [TAG_W-1:0]  way0Tag_i,
  input  logic              way0Valid_i,
  input  logic [LINE_W-1:0] way0Line_i,
  input  logic [TAG_W-1:0]  way1Tag_i,
  input  logic              way1Valid_i,
  input  logic [LINE_W-1:0] way1Line_i,
  // lookup and fill control to the ways
  output logic              lookupEn_o,
  output logic [IDX_W-1:0]  lookupIndex_o,
  output logic              fill0En_o,
  output logic              fill1En_o,
  output logic [IDX_W-1:0]  fillIndex_o,
  output logic [TAG_W-1:0]  fillTag_o,
  output logic [LINE_W-1:0] fillLine_o,
  // refill unit
  output logic              refillStart_o,
  output logic [ADDR_W-1:0] refillAddr_o,
  input  logic              refillDone_i,
  input  logic [LINE_W-1:0] refillLine_i
);

  // low address bits that select a byte inside the data word
  localparam int WORD_LSB = $clog2(XLEN / 8);

  cacheState_e stateQ, stateD;

  logic [ADDR_W-1:0]   reqAddr;
  logic [TAG_W-1:0]    reqTag;
  logic [IDX_W-1:0]    reqIdx;
  logic [OFFSET_W-WORD_LSB-1:0] wordSel;

  logic                way0Hit, way1Hit, cacheHit;
  logic                compareEn;
  logic                victimWay, victimQ;
  logic                fillDoneQ;
  logic [NUM_SETS-1:0] lruQ;
  logic [LINE_W-1:0]   hitLine;

  assign reqTag  = reqAddr[ADDR_W-1 -: TAG_W];
  assign reqIdx  = reqAddr[OFFSET_W +: IDX_W];
  assign wordSel = reqAddr[OFFSET_W-1:WORD_LSB];

  assign compareEn = (stateQ == COMPARE);
  assign way0Hit   = compareEn && way0Valid_i && (way0Tag_i == reqTag);
  assign way1Hit   = compareEn && way1Valid_i && (way1Tag_i == reqTag);
  assign cacheHit  = way0Hit || way1Hit;

  // take a new request when idle or while the current one hits
  assign addrOk_o = valid_i && ((stateQ == IDLE) || cacheHit);
  assign dataOk_o = cacheHit;

  assign hitLine  = way0Hit ? way0Line_i : way1Line_i;
  assign rdData_o = hitLine[wordSel*XLEN +: XLEN];

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      IDLE: begin
        if (valid_i) begin
          stateD = COMPARE;
        end
      end
      COMPARE: begin
        if (!cacheHit) begin
          stateD = MISS;
        end else if (!valid_i) begin
          stateD = IDLE;
        end
      end
      MISS: stateD = REFILL;
      REFILL: begin
        if (refillDone_i) begin
          stateD = FILL;
        end
      end
      // first cycle writes, second one looks up again
      FILL: begin
        if (fillDoneQ) begin
          stateD = COMPARE;
        end
      end
      default: stateD = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= IDLE;
    end else begin
      stateQ <= stateD;
    end
  end

  always_ff @(posedge clk) begin
    if (addrOk_o) begin
      reqAddr <= addr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fillDoneQ <= 1'b0;
    end else if (stateQ == FILL) begin
      fillDoneQ <= ~fillDoneQ;
    end else begin
      fillDoneQ <= 1'b0;
    end
  end

  // an empty way wins, way 0 first, else the LRU way
  assign victimWay = !way0Valid_i ? 1'b0 :
                     !way1Valid_i ? 1'b1 : lruQ[reqIdx];

  // lruQ names the less recently used way of each set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimQ <= 1'b0;
      lruQ    <= '0;
    end else begin
      if (compareEn && !cacheHit) begin
        victimQ <= victimWay;
      end
      if (cacheHit) begin
        lruQ[reqIdx] <= way0Hit;
      end else if (fill0En_o || fill1En_o) begin
        lruQ[reqIdx] <= ~victimQ;
      end
    end
  end

  assign lookupEn_o    = addrOk_o || ((stateQ == FILL) && fillDoneQ);
  assign lookupIndex_o = (stateQ == FILL) ? reqIdx : addr_i[OFFSET_W +: IDX_W];

  assign fill0En_o   = (stateQ == FILL) && !fillDoneQ && !victimQ;
  assign fill1En_o   = (stateQ == FILL) && !fillDoneQ && victimQ;
  assign fillIndex_o = reqIdx;
  assign fillTag_o   = reqTag;
  assign fillLine_o  = refillLine_i;

  assign refillStart_o = (stateQ == MISS);
  assign refillAddr_o  = {reqTag, reqIdx, {OFFSET_W{1'b0}}};

  // a line lives in at most one way, so two hits mean a broken fill
  assert property (@(posedge clk) disable iff (!rst_n) !(way0Hit && way1Hit))
    else $error("cacheCtrl: both ways hit");

endmodule

// ==== src/cachePkg.sv ====
package cachePkg;

  // data word seen by the pipeline
  parameter int XLEN = 64;

  // one line is four beats of the memory port
  parameter int LINE_BEATS = 4;
  parameter int LINE_W = XLEN * LINE_BEATS;

  // byte offset bits inside a 32-byte line
  parameter int OFFSET_W = 5;

  parameter int ADDR_W = 32;

  // controller states
  // COMPARE checks the registered way outputs against the latched tag,
  // FILL writes the victim and then looks the same address up again
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    COMPARE = 3'd1,
    MISS    = 3'd2,
    REFILL  = 3'd3,
    FILL    = 3'd4
  } cacheState_e;

endpackage

// ==== src/cacheTop.sv ====
`timescale 1ns/1ns

module cacheTop import cachePkg::*; #(
  parameter int NUM_SETS = 64,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
) (
  input  logic              clk,
  input  logic              rst_n,
  // pipeline
  input  logic              valid_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic              addrOk_o,
  output logic              dataOk_o,
  output logic [XLEN-1:0]   rdData_o,
  // memory
  output logic              memRdValid_o,
  output logic [ADDR_W-1:0] memAddr_o,
  input  logic              memRdBeat_i,
  input  logic              memRdLast_i,
  input  logic [XLEN-1:0]   memRdData_i
);

  logic              lookupEn;
  logic [IDX_W-1:0]  lookupIndex;
  logic              fill0En, fill1En;
  logic [IDX_W-1:0]  fillIndex;
  logic [TAG_W-1:0]  fillTag;
  logic [LINE_W-1:0] fillLine;

  logic [TAG_W-1:0]  way0Tag, way1Tag;
  logic              way0Valid, way1Valid;
  logic [LINE_W-1:0] way0Line, way1Line;

  logic              refillStart, refillDone;
  logic [ADDR_W-1:0] refillAddr;
  logic [LINE_W-1:0] refillLine;

  cacheWay #(.NUM_SETS(NUM_SETS)) uWay0 (
    .clk, .rst_n,
    .lookupEn_i(lookupEn), .lookupIndex_i(lookupIndex),
    .fillEn_i(fill0En), .fillIndex_i(fillIndex), .fillTag_i(fillTag), .fillLine_i(fillLine),
    .wayTag_o(way0Tag), .wayValid_o(way0Valid), .wayLine_o(way0Line)
  );

  cacheWay #(.NUM_SETS(NUM_SETS)) uWay1 (
    .clk, .rst_n,
    .lookupEn_i(lookupEn), .lookupIndex_i(lookupIndex),
    .fillEn_i(fill1En), .fillIndex_i(fillIndex), .fillTag_i(fillTag), .fillLine_i(fillLine),
    .wayTag_o(way1Tag), .wayValid_o(way1Valid), .wayLine_o(way1Line)
  );

  lineRefill uRefill (
    .clk, .rst_n,
    .refillStart_i(refillStart), .refillAddr_i(refillAddr),
    .memRdBeat_i, .memRdLast_i, .memRdData_i,
    .memRdValid_o, .memAddr_o,
    .refillDone_o(refillDone), .refillLine_o(refillLine)
  );

  cacheCtrl #(.NUM_SETS(NUM_SETS)) uCtrl (
    .clk, .rst_n,
    .valid_i, .addr_i, .addrOk_o, .dataOk_o, .rdData_o,
    .way0Tag_i(way0Tag), .way0Valid_i(way0Valid), .way0Line_i(way0Line),
    .way1Tag_i(way1Tag), .way1Valid_i(way1Valid), .way1Line_i(way1Line),
    .lookupEn_o(lookupEn), .lookupIndex_o(lookupIndex),
    .fill0En_o(fill0En), .fill1En_o(fill1En),
    .fillIndex_o(fillIndex), .fillTag_o(fillTag), .fillLine_o(fillLine),
    .refillStart_o(refillStart), .refillAddr_o(refillAddr),
    .refillDone_i(refillDone), .refillLine_i(refillLine)
  );

endmodule

// ==== src/cacheWay.sv ====
`timescale 1ns/1ns

module cacheWay import cachePkg::*; #(
  parameter int NUM_SETS = 64,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
) (
  input  logic              clk,
  input  logic              rst_n,
  // lookup side
  input  logic              lookupEn_i,
  input  logic [IDX_W-1:0]  lookupIndex_i,
  // line write from the refill path
  input  logic              fillEn_i,
  input  logic [IDX_W-1:0]  fillIndex_i,
  input  logic [TAG_W-1:0]  fillTag_i,
  input  logic [LINE_W-1:0] fillLine_i,
  // registered lookup result
  output logic [TAG_W-1:0]  wayTag_o,
  output logic              wayValid_o,
  output logic [LINE_W-1:0] wayLine_o
);

  // behavioural storage in place of SRAM macros
  logic [TAG_W-1:0]  tagArr  [NUM_SETS];
  logic [LINE_W-1:0] lineArr [NUM_SETS];
  logic [NUM_SETS-1:0] validQ;

  // valid bits start clear so every set misses after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
    end else if (fillEn_i) begin
      validQ[fillIndex_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[fillIndex_i]  <= fillTag_i;
      lineArr[fillIndex_i] <= fillLine_i;
    end
  end

  // read port, result visible in the COMPARE cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wayValid_o <= 1'b0;
    end else if (lookupEn_i) begin
      wayValid_o <= validQ[lookupIndex_i];
    end
  end

  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      wayTag_o  <= tagArr[lookupIndex_i];
      wayLine_o <= lineArr[lookupIndex_i];
    end
  end

  // the controller keeps the write and the re-lookup in separate FILL cycles
  assert property (@(posedge clk) disable iff (!rst_n) !(fillEn_i && lookupEn_i))
    else $error("cacheWay: fill and lookup in the same cycle");

endmodule

// ==== src/lineRefill.sv ====
`timescale 1ns/1ns

module lineRefill import cachePkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // request from the controller
  input  logic              refillStart_i,
  input  logic [ADDR_W-1:0] refillAddr_i,
  // beat-serial memory port
  input  logic              memRdBeat_i,
  input  logic              memRdLast_i,
  input  logic [XLEN-1:0]   memRdData_i,
  output logic              memRdValid_o,
  output logic [ADDR_W-1:0] memAddr_o,
  // assembled line back to the controller
  output logic              refillDone_o,
  output logic [LINE_W-1:0] refillLine_o
);

  localparam int BEAT_W = $clog2(LINE_BEATS);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(LINE_BEATS - 1);

  logic [BEAT_W-1:0] beatCnt;
  logic [LINE_W-1:0] lineQ;
  logic              beatTake;

  assign beatTake = memRdBeat_i && memRdValid_o;

  // request stays up from start until the last beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memRdValid_o <= 1'b0;
      memAddr_o    <= '0;
      beatCnt      <= '0;
      refillDone_o <= 1'b0;
    end else begin
      refillDone_o <= 1'b0;
      if (refillStart_i) begin
        memRdValid_o <= 1'b1;
        memAddr_o    <= refillAddr_i;
        beatCnt      <= '0;
      end else if (beatTake) begin
        beatCnt <= beatCnt + 1'b1;
        if (memRdLast_i) begin
          memRdValid_o <= 1'b0;
          refillDone_o <= 1'b1;
        end
      end
    end
  end

  // beat n lands in bits n*64 and up
  always_ff @(posedge clk) begin
    if (beatTake) begin
      lineQ[beatCnt*XLEN +: XLEN] <= memRdData_i;
    end
  end

  // held until the next refill overwrites it
  assign refillLine_o = lineQ;

  assert property (@(posedge clk) disable iff (!rst_n) memRdBeat_i |-> memRdValid_o)
    else $error("lineRefill: beat without an open request");

  // last strobe must line up with the fourth counted beat
  assert property (@(posedge clk) disable iff (!rst_n)
    memRdLast_i == (memRdBeat_i && beatCnt == LAST_BEAT))
    else $error("lineRefill: last strobe not on the fourth beat");

endmodule

// ==== tb.f ====
src/cachePkg.sv
src/cacheWay.sv
src/lineRefill.sv
src/cacheCtrl.sv
src/cacheTop.sv
verification/memModel.sv
verification/cacheTb.sv

// ==== verification/cacheTb.sv ====
`timescale 1ns/1ns

module cacheTb import cachePkg::*; ();

  localparam int NUM_SETS       = 64;
  localparam int IDX_W          = $clog2(NUM_SETS);
  localparam int TAG_W          = ADDR_W - OFFSET_W - IDX_W;
  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_REQ        = 400;
  localparam int LRU_REQS       = 5;
  localparam int MAX_REQ_CYCLES = 30;

  typedef struct {
    logic [ADDR_W-1:0] addr;
    bit                hit;
    bit                victim;
    int                acceptCycle;
    bit                directed;
    bit                expHit;
  } pendingReq_t;

  logic              clk, rst_n;
  logic              valid, addrOk, dataOk;
  logic [ADDR_W-1:0] addr, memAddr;
  logic [XLEN-1:0]   rdData, memRdData;
  logic              memRdValid, memRdBeat, memRdLast;

  integer      seed;
  int          cycleCnt;
  int          doneCount;
  int          memReqCount;
  bit          memValidSeen;
  pendingReq_t pending[$];
  // expected hit pattern of the LRU sequence
  bit          directedHit[$];

  // reference model with one entry per set and way
  logic [TAG_W-1:0] modelTag   [NUM_SETS][2];
  bit               modelValid [NUM_SETS][2];
  bit               modelLru   [NUM_SETS];

  cacheTop #(.NUM_SETS(NUM_SETS)) DUT (
    .clk, .rst_n,
    .valid_i(valid), .addr_i(addr),
    .addrOk_o(addrOk), .dataOk_o(dataOk), .rdData_o(rdData),
    .memRdValid_o(memRdValid), .memAddr_o(memAddr),
    .memRdBeat_i(memRdBeat), .memRdLast_i(memRdLast), .memRdData_i(memRdData)
  );

  memModel uMem (
    .clk, .rst_n,
    .memRdValid_i(memRdValid), .memAddr_i(memAddr),
    .memRdBeat_o(memRdBeat), .memRdLast_o(memRdLast), .memRdData_o(memRdData)
  );

  task automatic reportFail(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [ADDR_W-1:0] makeAddr(input logic [TAG_W-1:0] tag,
                                                 input logic [IDX_W-1:0] idx,
                                                 input logic [1:0] word);
    return {tag, idx, word, 3'b000};
  endfunction

  // predicts hit or miss and updates tag, valid and LRU state
  function automatic bit modelAccess(input logic [ADDR_W-1:0] a, output bit victim);
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    idx    = a[OFFSET_W +: IDX_W];
    tag    = a[ADDR_W-1 -: TAG_W];
    victim = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (modelValid[idx][w] && modelTag[idx][w] == tag) begin
        // LRU bit points at the other way
        modelLru[idx] = (w == 0);
        return 1'b1;
      end
    end
    if (!modelValid[idx][0]) begin
      victim = 1'b0;
    end else if (!modelValid[idx][1]) begin
      victim = 1'b1;
    end else begin
      victim = modelLru[idx];
    end
    modelValid[idx][victim] = 1'b1;
    modelTag[idx][victim]   = tag;
    modelLru[idx]           = !victim;
    return 1'b0;
  endfunction

  // called and returning a small delay after a rising edge
  task automatic issueRequest(input logic [ADDR_W-1:0] a);
    valid = 1'b1;
    addr  = a;
    @(negedge clk);
    while (!addrOk) @(negedge clk);
    @(posedge clk);
    #1;
    valid = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + NUM_REQ * MAX_REQ_CYCLES));
    $display("Watchdog timeout: %0d of %0d requests completed", doneCount, NUM_REQ);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  // sampled on the falling edge away from input and register updates
  always @(negedge clk) begin : monitor
    pendingReq_t front;
    pendingReq_t req;
    logic [ADDR_W-1:0] wordAddr;
    logic [XLEN-1:0]   expWord;
    if (rst_n) begin
      cycleCnt++;
      assert (!(addrOk && (memRdValid || DUT.uCtrl.stateQ == MISS ||
                DUT.uCtrl.stateQ == REFILL || DUT.uCtrl.stateQ == FILL)))
        else reportFail("addrOk_o high while a miss is being served");

      if (DUT.uCtrl.fill0En_o || DUT.uCtrl.fill1En_o) begin
        assert (pending.size() > 0 && !pending[0].hit)
          else reportFail("way fill without an outstanding miss");
        assert (DUT.uCtrl.fill1En_o == pending[0].victim)
          else reportFail($sformatf("addr %h filled way %0d, expected way %0d",
                                    pending[0].addr, DUT.uCtrl.fill1En_o, pending[0].victim));
      end

      if (dataOk) begin
        assert (pending.size() > 0) else reportFail("dataOk_o with no request outstanding");
        front    = pending.pop_front();
        wordAddr = {front.addr[ADDR_W-1:3], 3'b000};
        expWord  = {wordAddr, ~wordAddr};
        assert (rdData === expWord)
          else reportFail($sformatf("addr %h read %h, expected %h", front.addr, rdData, expWord));
        if (front.hit) begin
          assert (cycleCnt == front.acceptCycle + 1)
            else reportFail($sformatf("hit at %h took %0d cycles, expected 1",
                                      front.addr, cycleCnt - front.acceptCycle));
          assert (memReqCount == 0)
            else reportFail($sformatf("hit at %h made a memory request", front.addr));
        end else begin
          assert (memReqCount == 1)
            else reportFail($sformatf("miss at %h made %0d memory requests, expected 1",
                                      front.addr, memReqCount));
        end
        if (front.directed) begin
          assert ((memReqCount == 0) == front.expHit)
            else reportFail($sformatf("LRU sequence addr %h hit %0d, expected %0d",
                                      front.addr, memReqCount == 0, front.expHit));
        end
        memReqCount = 0;
        doneCount++;
      end

      // one rising memRdValid_o per miss
      if (memRdValid && !memValidSeen) begin
        assert (pending.size() > 0) else reportFail("memory request with no request outstanding");
        memReqCount++;
        assert (memAddr === {pending[0].addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}})
          else reportFail($sformatf("memAddr_o %h for request %h", memAddr, pending[0].addr));
      end
      memValidSeen = memRdValid;

      if (valid && addrOk) begin
        req.addr        = addr;
        req.hit         = modelAccess(addr, req.victim);
        req.acceptCycle = cycleCnt;
        req.directed    = (directedHit.size() > 0);
        req.expHit      = 1'b0;
        if (req.directed) begin
          req.expHit = directedHit.pop_front();
        end
        pending.push_back(req);
      end
    end
  end

  initial begin : stimulus
    logic [TAG_W-1:0] tagPool [4];
    logic [IDX_W-1:0] setPool [3];
    logic [TAG_W-1:0] lruTag  [3];
    int               lruOrder [LRU_REQS];
    int               gap;
    int               tagPick;
    int               setPick;
    logic [1:0]       wordPick;
    seed     = 32'h11e9;
    tagPool  = '{TAG_W'(0), TAG_W'(1), TAG_W'('h0a5a5), TAG_W'('h1fff0)};
    setPool  = '{IDX_W'(0), IDX_W'(17), IDX_W'(NUM_SETS - 1)};
    lruTag   = '{TAG_W'('h100), TAG_W'('h101), TAG_W'('h102)};
    lruOrder = '{0, 1, 2, 0, 2};
    rst_n = 1'b0;
    valid = 1'b0;
    addr  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (!addrOk && !dataOk && !memRdValid)
      else reportFail("addrOk_o, dataOk_o or memRdValid_o high after reset");
    @(posedge clk);
    #1;

    // three tags in set 5 where the oldest is evicted and the newest stays
    directedHit = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    foreach (lruOrder[i]) begin
      issueRequest(makeAddr(lruTag[lruOrder[i]], IDX_W'(5), 2'(i)));
    end

    for (int n = LRU_REQS; n < NUM_REQ; n++) begin
      gap = $random(seed) & 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      tagPick  = $random(seed) & 3;
      setPick  = ($random(seed) & 32'h7fffffff) % 3;
      wordPick = 2'($random(seed));
      issueRequest(makeAddr(tagPool[tagPick], setPool[setPick], wordPick));
    end

    wait (doneCount == NUM_REQ);
    repeat (2) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verification/memModel.sv ====
`timescale 1ns/1ns

module memModel import cachePkg::*; #(
  parameter int SEED = 32'h11e9
) (
  input  logic              clk,
  input  logic              rst_n,
  // request from the cache
  input  logic              memRdValid_i,
  input  logic [ADDR_W-1:0] memAddr_i,
  // beat-serial response
  output logic              memRdBeat_o,
  output logic              memRdLast_o,
  output logic [XLEN-1:0]   memRdData_o
);

  integer seed;

  // address in the upper half, its inverse in the lower half
  function automatic logic [XLEN-1:0] beatWord(input logic [ADDR_W-1:0] byteAddr);
    return {byteAddr, ~byteAddr};
  endfunction

  // outputs change a small delay after the rising edge
  task automatic waitCycle();
    @(posedge clk);
    #1;
  endtask

  initial begin
    int gap;
    logic [ADDR_W-1:0] lineBase;
    seed        = SEED;
    memRdBeat_o = 1'b0;
    memRdLast_o = 1'b0;
    memRdData_o = '0;
    forever begin
      waitCycle();
      if (rst_n && memRdValid_i) begin
        lineBase = memAddr_i;
        for (int beat = 0; beat < LINE_BEATS; beat++) begin
          // idle cycles before each beat
          gap = $random(seed) & 3;
          repeat (gap) waitCycle();
          memRdBeat_o = 1'b1;
          memRdLast_o = (beat == LINE_BEATS - 1);
          memRdData_o = beatWord(lineBase + ADDR_W'(beat * (XLEN / 8)));
          waitCycle();
          memRdBeat_o = 1'b0;
          memRdLast_o = 1'b0;
        end
      end
    end
  end

endmodule
